/* Bender.yml */
package:
  name: exe_stage

sources:
  - hdl/isa_pkg.sv
  - hdl/exe_pkg.sv
  - hdl/instr_decode.sv
  - hdl/alu.sv
  - hdl/reg_file.sv
  - hdl/hilo_unit.sv
  - hdl/branch_unit.sv
  - hdl/exe_commit.sv
  - hdl/exe_stage.sv
  - target: test
    files:
      - bench/exe_stage_tb.sv

/* bench/exe_stage_tb.sv */
`timescale 1ns/1ps

module exe_stage_tb;

    localparam int          clk_period = 20;
    localparam logic [31:0] sp_init    = 32'hfffff000;
    localparam logic [31:0] pc_base    = 32'h00400000;

    typedef struct packed {
        logic        issue;
        logic [31:0] instr;
        logic [31:0] pc_plus4;
        logic [31:0] load_data;    // answers the lw of the previous entry
        logic        exp_we;
        logic        exp_re;
        logic [31:0] exp_addr;
        logic [31:0] exp_wdata;
        logic        exp_jv;
        logic [25:0] exp_jt;
        logic        exp_bv;
        logic [15:0] exp_bo;
        logic [31:0] exp_hi;
        logic [31:0] exp_lo;
    } vec_t;

    logic              clk_i;
    logic              reset_i;
    logic              issue_i;
    isa_pkg::instr_t   instr_i;
    logic [31:0]       pc_plus4_i;
    logic [31:0]       load_data_i;
    exe_pkg::mem_req_t mem_req_o;
    exe_pkg::jump_t    jump_o;
    exe_pkg::branch_t  branch_o;
    logic [31:0]       hi_o;
    logic [31:0]       lo_o;

    vec_t        vec_q[$];
    logic [31:0] cur_hi;
    logic [31:0] cur_lo;
    logic [15:0] store_off;
    integer      seed;
    bit          table_ready;

    exe_stage #(.sp_init(sp_init)) i_dut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .issue_i     (issue_i),
        .instr_i     (instr_i),
        .pc_plus4_i  (pc_plus4_i),
        .load_data_i (load_data_i),
        .mem_req_o   (mem_req_o),
        .jump_o      (jump_o),
        .branch_o    (branch_o),
        .hi_o        (hi_o),
        .lo_o        (lo_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(clk_period / 2) clk_i = ~clk_i;
    end

    ////////////////////
    // instruction encoding
    ////////////////////
    function automatic logic [31:0] r_format(input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [4:0] rd, input logic [4:0] sh,
                                             input logic [5:0] fn);
        return {6'b000000, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_format(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_format(input logic [5:0] op, input logic [25:0] tgt);
        return {op, tgt};
    endfunction

    ////////////////////
    // table building
    ////////////////////
    function automatic vec_t blank_entry(input logic [31:0] instr);
        vec_t v;
        v          = '0;
        v.issue    = 1'b1;
        v.instr    = instr;
        v.pc_plus4 = pc_base + 4 * (vec_q.size() + 1);
        v.exp_hi   = cur_hi;    // hi/lo as left by earlier entries
        v.exp_lo   = cur_lo;
        return v;
    endfunction

    task automatic push_instr(input logic [31:0] instr);
        vec_q.push_back(blank_entry(instr));
    endtask

    task automatic expect_store(input logic [4:0] rt, input logic [31:0] data,
                                input logic [31:0] ld);
        vec_t v;
        v           = blank_entry(i_format(isa_pkg::op_sw, 5'd0, rt, store_off));
        v.load_data = ld;
        v.exp_we    = 1'b1;
        v.exp_addr  = {16'h0000, store_off};    // r0 base
        v.exp_wdata = data;
        vec_q.push_back(v);
        store_off   = store_off + 16'd4;
    endtask

    task automatic compute_and_store(input logic [31:0] instr, input logic [4:0] rd,
                                     input logic [31:0] data);
        push_instr(instr);
        expect_store(rd, data, 32'd0);          // back to back, uses the bypass
    endtask

    task automatic load_then_store(input logic [4:0] rt, input logic [4:0] base,
                                   input logic [31:0] base_val, input logic [15:0] off,
                                   input logic [31:0] ld);
        vec_t v;
        v          = blank_entry(i_format(isa_pkg::op_lw, base, rt, off));
        v.exp_re   = 1'b1;
        v.exp_addr = base_val + {{16{off[15]}}, off};
        vec_q.push_back(v);
        expect_store(rt, ld, ld);
    endtask

    task automatic branch_case(input logic [5:0] op, input logic [4:0] rs, input logic [4:0] rt,
                               input logic [15:0] off, input logic taken);
        vec_t v;
        v        = blank_entry(i_format(op, rs, rt, off));
        v.exp_bv = taken;
        v.exp_bo = off;
        vec_q.push_back(v);
    endtask

    task automatic jump_case(input logic [31:0] instr, input logic [25:0] tgt,
                             output logic [31:0] link);
        vec_t v;
        v        = blank_entry(instr);
        v.exp_jv = 1'b1;
        v.exp_jt = tgt;
        link     = v.pc_plus4;
        vec_q.push_back(v);
    endtask

    task automatic build_table();
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     ld;
        logic [31:0]     link;
        logic [4:0]      sh;
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        logic [63:0]     p;
        vec_t            v;

        seed      = 23649;
        cur_hi    = '0;
        cur_lo    = '0;
        store_off = 16'h0100;

        expect_store(29, sp_init, 32'd0);       // stack pointer after reset
        compute_and_store(i_format(isa_pkg::op_addi, 0, 1, 16'hfffb), 1, 32'hfffffffb);
        compute_and_store(i_format(isa_pkg::op_addiu, 1, 2, 16'h8000), 2, 32'h00007ffb);
        compute_and_store(i_format(isa_pkg::op_ori, 0, 3, 16'h8001), 3, 32'h00008001);
        compute_and_store(i_format(isa_pkg::op_lui, 0, 4, 16'hbeef), 4, 32'hbeef0000);
        compute_and_store(i_format(isa_pkg::op_slti, 1, 11, 16'h0001), 11, 32'd1);
        compute_and_store(i_format(isa_pkg::op_sltiu, 1, 12, 16'hffff), 12, 32'd0);
        compute_and_store(i_format(isa_pkg::op_andi, 1, 13, 16'hf0f0), 13, 32'h0000f0f0);
        compute_and_store(i_format(isa_pkg::op_xori, 1, 14, 16'h00ff), 14, 32'hffffff04);

        for (int round = 0; round < 2; round++) begin
            a  = $random(seed);
            b  = $random(seed);
            ld = $random(seed);
            sh = ld[4:0];
            push_instr(i_format(isa_pkg::op_lui, 0, 5, a[31:16]));
            compute_and_store(i_format(isa_pkg::op_ori, 5, 5, a[15:0]), 5, a);
            push_instr(i_format(isa_pkg::op_lui, 0, 6, b[31:16]));
            compute_and_store(i_format(isa_pkg::op_ori, 6, 6, b[15:0]), 6, b);
            compute_and_store(r_format(0, 6, 7, sh, isa_pkg::fn_sll), 7, b << sh);
            compute_and_store(r_format(0, 6, 7, sh, isa_pkg::fn_srl), 7, b >> sh);
            compute_and_store(r_format(0, 6, 7, sh, isa_pkg::fn_sra), 7, $signed(b) >>> sh);
            compute_and_store(r_format(5, 6, 7, 0, isa_pkg::fn_sllv), 7, b << a[4:0]);
            compute_and_store(r_format(5, 6, 7, 0, isa_pkg::fn_srlv), 7, b >> a[4:0]);
            compute_and_store(r_format(5, 6, 7, 0, isa_pkg::fn_srav), 7, $signed(b) >>> a[4:0]);
            compute_and_store(r_format(5, 6, 7, 0, isa_pkg::fn_add), 7, a + b);
            compute_and_store(r_format(5, 6, 7, 0, isa_pkg::fn_subu), 7, a - b);
            compute_and_store(r_format(5, 6, 7, 0, isa_pkg::fn_and), 7, a & b);
            compute_and_store(r_format(5, 6, 7, 0, isa_pkg::fn_or), 7, a | b);
            compute_and_store(r_format(5, 6, 7, 0, isa_pkg::fn_xor), 7, a ^ b);
            compute_and_store(r_format(5, 6, 7, 0, isa_pkg::fn_nor), 7, ~(a | b));
            compute_and_store(r_format(5, 6, 7, 0, isa_pkg::fn_slt), 7,
                              {31'b0, $signed(a) < $signed(b)});
            compute_and_store(r_format(5, 6, 7, 0, isa_pkg::fn_sltu), 7, {31'b0, a < b});
            compute_and_store(r_format(5, 6, 0, 0, isa_pkg::fn_add), 0, 32'd0);   // r0 stays 0
        end

        ld = $random(seed);
        load_then_store(8, 5, a, 16'hfff8, ld);
        expect_store(8, ld, 32'd0);             // now from the array itself

        sa = $signed(a);
        sb = $signed(b);
        p  = sa * sb;
        {cur_hi, cur_lo} = p;
        push_instr(r_format(5, 6, 0, 0, isa_pkg::fn_mult));
        ua = a;
        ub = b;
        p  = ua * ub;
        {cur_hi, cur_lo} = p;
        push_instr(r_format(5, 6, 0, 0, isa_pkg::fn_multu));
        compute_and_store(r_format(0, 0, 9, 0, isa_pkg::fn_mfhi), 9, cur_hi);
        compute_and_store(r_format(0, 0, 10, 0, isa_pkg::fn_mflo), 10, cur_lo);

        branch_case(isa_pkg::op_beq, 5, 5, 16'h0010, 1'b1);
        branch_case(isa_pkg::op_beq, 5, 6, 16'h0020, a == b);
        branch_case(isa_pkg::op_bne, 5, 6, 16'hfff0, a != b);
        branch_case(isa_pkg::op_bne, 5, 5, 16'h0040, 1'b0);
        jump_case(j_format(isa_pkg::op_j, 26'h0123456), 26'h0123456, link);
        jump_case(r_format(5, 0, 0, 0, isa_pkg::fn_jr), a[25:0], link);
        jump_case(j_format(isa_pkg::op_jal, 26'h02abcde), 26'h02abcde, link);

        v       = blank_entry(i_format(isa_pkg::op_sw, 0, 29, 16'h0000));
        v.issue = 1'b0;                         // idle, store must not fire
        vec_q.push_back(v);
        expect_store(31, link, 32'd0);
    endtask

    ////////////////////
    // driving and checking
    ////////////////////
    task automatic drive_entry(input vec_t e);
        issue_i     = e.issue;
        instr_i     = e.instr;
        pc_plus4_i  = e.pc_plus4;
        load_data_i = e.load_data;
    endtask

    task automatic abort_run(input string reason);
        $display("CHECKS FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic report_mismatch(input string what, input int idx,
                                   input logic [31:0] got, input logic [31:0] exp);
        $display("[ERROR] %0d ns: entry %0d, %s is %h, expected %h",
                 $time, idx, what, got, exp);
        abort_run("value mismatch");
    endtask

    task automatic check_entry(input vec_t e, input int idx);
        assert (mem_req_o.we == e.exp_we)
            else report_mismatch("mem write enable", idx, mem_req_o.we, e.exp_we);
        assert (mem_req_o.re == e.exp_re)
            else report_mismatch("mem load enable", idx, mem_req_o.re, e.exp_re);
        if (e.exp_we || e.exp_re) begin
            assert (mem_req_o.addr == e.exp_addr)
                else report_mismatch("mem address", idx, mem_req_o.addr, e.exp_addr);
        end
        if (e.exp_we) begin
            assert (mem_req_o.wdata == e.exp_wdata)
                else report_mismatch("store data", idx, mem_req_o.wdata, e.exp_wdata);
        end
        assert (jump_o.valid == e.exp_jv)
            else report_mismatch("jump valid", idx, jump_o.valid, e.exp_jv);
        if (e.exp_jv) begin
            assert (jump_o.target == e.exp_jt)
                else report_mismatch("jump target", idx, jump_o.target, e.exp_jt);
        end
        assert (branch_o.valid == e.exp_bv)
            else report_mismatch("branch valid", idx, branch_o.valid, e.exp_bv);
        if (e.exp_bv) begin
            assert (branch_o.offset == e.exp_bo)
                else report_mismatch("branch offset", idx, branch_o.offset, e.exp_bo);
        end
        assert (hi_o == e.exp_hi) else report_mismatch("hi", idx, hi_o, e.exp_hi);
        assert (lo_o == e.exp_lo) else report_mismatch("lo", idx, lo_o, e.exp_lo);
    endtask

    initial begin
        reset_i     = 1'b1;
        issue_i     = 1'b0;
        instr_i     = '0;
        pc_plus4_i  = '0;
        load_data_i = '0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;

        repeat (5) @(posedge clk_i);
        #2;
        reset_i = 1'b0;
        check_entry('0, -1);                    // everything cleared by reset

        // outputs of entry i-1 settle at the edge where entry i is driven
        for (int i = 0; i <= vec_q.size(); i++) begin
            @(posedge clk_i);
            #2;
            if (i > 0) begin
                check_entry(vec_q[i-1], i - 1);
            end
            if (i < vec_q.size()) begin
                drive_entry(vec_q[i]);
            end else begin
                issue_i = 1'b0;
            end
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin
        wait (table_ready);
        #((vec_q.size() + 20) * clk_period * 2);
        $display("timeout: the stimulus table did not finish in time");
        abort_run("watchdog expired");
    end

endmodule

/* exe_stage.f */
hdl/isa_pkg.sv
hdl/exe_pkg.sv
hdl/instr_decode.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/hilo_unit.sv
hdl/branch_unit.sv
hdl/exe_commit.sv
hdl/exe_stage.sv
bench/exe_stage_tb.sv

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  exe_pkg::decoded_t          dec_i,
    input  logic [isa_pkg::xlen-1:0]   rs_val_i,
    input  logic [isa_pkg::xlen-1:0]   rt_val_i,
    input  logic [isa_pkg::xlen-1:0]   hi_i,
    input  logic [isa_pkg::xlen-1:0]   lo_i,
    input  logic [isa_pkg::xlen-1:0]   pc_plus4_i,
    output logic [isa_pkg::xlen-1:0]   result_o,
    output logic [isa_pkg::xlen-1:0]   mem_addr_o
);

    logic [isa_pkg::reg_addr_w-1:0] var_sh;
    logic                           lt_s;
    logic                           lt_u;
    logic                           lt_si;
    logic                           lt_ui;

    assign var_sh = rs_val_i[isa_pkg::reg_addr_w-1:0];  // variable shifts use rs[4:0]

    assign lt_s  = $signed(rs_val_i) < $signed(rt_val_i);
    assign lt_u  = rs_val_i < rt_val_i;
    assign lt_si = $signed(rs_val_i) < $signed(dec_i.imm);
    assign lt_ui = rs_val_i < dec_i.imm;

    assign mem_addr_o = rs_val_i + dec_i.imm;           // lw/sw base + offset

    always_comb begin
        result_o = '0;
        case (dec_i.op)
            exe_pkg::exe_sll:   result_o = rt_val_i << dec_i.shamt;
            exe_pkg::exe_srl:   result_o = rt_val_i >> dec_i.shamt;
            exe_pkg::exe_sra:   result_o = $signed(rt_val_i) >>> dec_i.shamt;
            exe_pkg::exe_sllv:  result_o = rt_val_i << var_sh;
            exe_pkg::exe_srlv:  result_o = rt_val_i >> var_sh;
            exe_pkg::exe_srav:  result_o = $signed(rt_val_i) >>> var_sh;
            exe_pkg::exe_add,
            exe_pkg::exe_addu:  result_o = rs_val_i + rt_val_i;   // no overflow trap
            exe_pkg::exe_addi,
            exe_pkg::exe_addiu: result_o = rs_val_i + dec_i.imm;
            exe_pkg::exe_sub,
            exe_pkg::exe_subu:  result_o = rs_val_i - rt_val_i;
            exe_pkg::exe_and:   result_o = rs_val_i & rt_val_i;
            exe_pkg::exe_andi:  result_o = rs_val_i & dec_i.imm;
            exe_pkg::exe_or:    result_o = rs_val_i | rt_val_i;
            exe_pkg::exe_ori:   result_o = rs_val_i | dec_i.imm;
            exe_pkg::exe_xor:   result_o = rs_val_i ^ rt_val_i;
            exe_pkg::exe_xori:  result_o = rs_val_i ^ dec_i.imm;
            exe_pkg::exe_nor:   result_o = ~(rs_val_i | rt_val_i);
            exe_pkg::exe_slt:   result_o = {31'b0, lt_s};
            exe_pkg::exe_sltu:  result_o = {31'b0, lt_u};
            exe_pkg::exe_slti:  result_o = {31'b0, lt_si};
            exe_pkg::exe_sltiu: result_o = {31'b0, lt_ui};
            exe_pkg::exe_lui:   result_o = {dec_i.imm[15:0], 16'b0};
            exe_pkg::exe_mfhi:  result_o = hi_i;
            exe_pkg::exe_mflo:  result_o = lo_i;
            exe_pkg::exe_jal:   result_o = pc_plus4_i;    // link value
            default:            result_o = '0;
        endcase
    end

endmodule

/* hdl/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              issue_i,
    input  exe_pkg::decoded_t dec_i,
    input  logic [31:0]       rs_val_i,
    input  logic [31:0]       rt_val_i,
    output exe_pkg::jump_t    jump_o,
    output exe_pkg::branch_t  branch_o
);

    logic is_jump;
    logic taken;

    assign is_jump = dec_i.op == exe_pkg::exe_j  ||
                     dec_i.op == exe_pkg::exe_jal ||
                     dec_i.op == exe_pkg::exe_jr;

    always_comb begin
        case (dec_i.op)
            exe_pkg::exe_beq: taken = rs_val_i == rt_val_i;
            exe_pkg::exe_bne: taken = rs_val_i != rt_val_i;
            default:          taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            jump_o.valid   <= 1'b0;
            branch_o.valid <= 1'b0;
        end else begin
            jump_o.valid   <= issue_i && is_jump;    // one cycle only
            branch_o.valid <= issue_i && taken;
        end

        if (dec_i.op == exe_pkg::exe_jr) begin
            jump_o.target <= rs_val_i[25:0];
        end else begin
            jump_o.target <= dec_i.jtarget;
        end
        branch_o.offset <= dec_i.imm[15:0];          // raw offset, not scaled
    end

endmodule

/* hdl/exe_commit.sv */
`timescale 1ns/1ps

module exe_commit (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              issue_i,
    input  exe_pkg::decoded_t dec_i,
    input  logic [31:0]       result_i,
    input  logic [31:0]       mem_addr_i,
    input  logic [31:0]       rt_val_i,
    input  logic [31:0]       load_data_i,
    output exe_pkg::wb_req_t  wb_o,
    output exe_pkg::mem_req_t mem_req_o
);

    exe_pkg::wb_req_t alu_wb_q;
    logic [4:0]       ld_idx_q;
    logic             is_load;
    logic             is_store;

    assign is_load  = dec_i.op == exe_pkg::exe_lw;
    assign is_store = dec_i.op == exe_pkg::exe_sw;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            alu_wb_q.we   <= 1'b0;
            mem_req_o.we  <= 1'b0;
            mem_req_o.re  <= 1'b0;
        end else begin
            alu_wb_q.we   <= issue_i && dec_i.dest != 5'd0 && !is_load;
            mem_req_o.we  <= issue_i && is_store;
            mem_req_o.re  <= issue_i && is_load;   // also marks the load pending
        end

        alu_wb_q.idx    <= dec_i.dest;
        alu_wb_q.data   <= result_i;
        ld_idx_q        <= dec_i.dest;
        mem_req_o.addr  <= mem_addr_i;
        mem_req_o.wdata <= rt_val_i;
    end

    ////////////////////
    // load data returns in the request cycle
    ////////////////////
    always_comb begin
        if (mem_req_o.re) begin
            wb_o.we   = 1'b1;
            wb_o.idx  = ld_idx_q;
            wb_o.data = load_data_i;
        end else begin
            wb_o = alu_wb_q;
        end
    end

endmodule

/* hdl/exe_pkg.sv */
package exe_pkg;

    typedef enum logic [5:0] {
        exe_nop,
        exe_sll, exe_srl, exe_sra, exe_sllv, exe_srlv, exe_srav,
        exe_add, exe_addu, exe_sub, exe_subu,
        exe_and, exe_or, exe_xor, exe_nor, exe_slt, exe_sltu,
        exe_addi, exe_addiu, exe_slti, exe_sltiu,
        exe_andi, exe_ori, exe_xori, exe_lui,
        exe_lw, exe_sw, exe_beq, exe_bne,
        exe_j, exe_jal, exe_jr,
        exe_mult, exe_multu, exe_mfhi, exe_mflo
    } exe_op_e;

    typedef struct packed {
        exe_op_e                         op;
        logic [isa_pkg::reg_addr_w-1:0]  rs;
        logic [isa_pkg::reg_addr_w-1:0]  rt;
        logic [isa_pkg::reg_addr_w-1:0]  dest;    // 0 means no write
        logic [isa_pkg::xlen-1:0]        imm;     // already extended
        logic [isa_pkg::reg_addr_w-1:0]  shamt;
        logic [25:0]                     jtarget;
    } decoded_t;

    typedef struct packed {
        logic                            we;
        logic [isa_pkg::reg_addr_w-1:0]  idx;
        logic [isa_pkg::xlen-1:0]        data;
    } wb_req_t;

    typedef struct packed {
        logic [isa_pkg::xlen-1:0]        addr;
        logic                            we;
        logic                            re;
        logic [isa_pkg::xlen-1:0]        wdata;
    } mem_req_t;

    typedef struct packed {
        logic                            valid;
        logic [25:0]                     target;
    } jump_t;

    typedef struct packed {
        logic                            valid;
        logic [15:0]                     offset;
    } branch_t;

endpackage

/* hdl/exe_stage.sv */
`timescale 1ns/1ps

module exe_stage #(
    parameter logic [31:0] sp_init = 32'hfffff000
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              issue_i,
    input  isa_pkg::instr_t   instr_i,
    input  logic [31:0]       pc_plus4_i,
    input  logic [31:0]       load_data_i,
    output exe_pkg::mem_req_t mem_req_o,
    output exe_pkg::jump_t    jump_o,
    output exe_pkg::branch_t  branch_o,
    output logic [31:0]       hi_o,
    output logic [31:0]       lo_o
);

    exe_pkg::decoded_t dec;
    exe_pkg::wb_req_t  wb;
    logic [31:0]       rs_val;
    logic [31:0]       rt_val;
    logic [31:0]       result;
    logic [31:0]       mem_addr;

    instr_decode i_decode (
        .instr_i (instr_i),
        .dec_o   (dec)
    );

    reg_file #(.sp_init(sp_init)) i_regs (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .rs_addr_i (dec.rs),
        .rt_addr_i (dec.rt),
        .wb_i      (wb),
        .rs_val_o  (rs_val),
        .rt_val_o  (rt_val)
    );

    alu i_alu (
        .dec_i      (dec),
        .rs_val_i   (rs_val),
        .rt_val_i   (rt_val),
        .hi_i       (hi_o),
        .lo_i       (lo_o),
        .pc_plus4_i (pc_plus4_i),
        .result_o   (result),
        .mem_addr_o (mem_addr)
    );

    hilo_unit i_hilo (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .issue_i  (issue_i),
        .dec_i    (dec),
        .rs_val_i (rs_val),
        .rt_val_i (rt_val),
        .hi_o     (hi_o),
        .lo_o     (lo_o)
    );

    branch_unit i_branch (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .issue_i  (issue_i),
        .dec_i    (dec),
        .rs_val_i (rs_val),
        .rt_val_i (rt_val),
        .jump_o   (jump_o),
        .branch_o (branch_o)
    );

    exe_commit i_commit (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .issue_i     (issue_i),
        .dec_i       (dec),
        .result_i    (result),
        .mem_addr_i  (mem_addr),
        .rt_val_i    (rt_val),
        .load_data_i (load_data_i),
        .wb_o        (wb),
        .mem_req_o   (mem_req_o)
    );

endmodule

/* hdl/hilo_unit.sv */
`timescale 1ns/1ps

module hilo_unit (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              issue_i,
    input  exe_pkg::decoded_t dec_i,
    input  logic [31:0]       rs_val_i,
    input  logic [31:0]       rt_val_i,
    output logic [31:0]       hi_o,
    output logic [31:0]       lo_o
);

    logic [63:0] prod;

    always_comb begin
        if (dec_i.op == exe_pkg::exe_mult) begin
            prod = $signed(rs_val_i) * $signed(rt_val_i);   // sign extended to 64
        end else begin
            prod = rs_val_i * rt_val_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            hi_o <= '0;
            lo_o <= '0;
        end else if (issue_i && (dec_i.op == exe_pkg::exe_mult ||
                                 dec_i.op == exe_pkg::exe_multu)) begin
            {hi_o, lo_o} <= prod;
        end
    end

endmodule

/* hdl/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode (
    input  isa_pkg::instr_t   instr_i,
    output exe_pkg::decoded_t dec_o
);

    logic [15:0] imm16;

    assign imm16 = instr_i[15:0];

    always_comb begin
        dec_o.op      = exe_pkg::exe_nop;
        dec_o.rs      = instr_i.rs;
        dec_o.rt      = instr_i.rt;
        dec_o.dest    = '0;
        dec_o.imm     = {16'b0, imm16};         // zero extend unless told otherwise
        dec_o.shamt   = instr_i.shamt;
        dec_o.jtarget = instr_i[25:0];

        case (isa_pkg::opcode_e'(instr_i.opcode))
            isa_pkg::op_rtype: begin
                dec_o.dest = instr_i.rd;
                case (isa_pkg::funct_e'(instr_i.funct))
                    isa_pkg::fn_sll:   dec_o.op = exe_pkg::exe_sll;
                    isa_pkg::fn_srl:   dec_o.op = exe_pkg::exe_srl;
                    isa_pkg::fn_sra:   dec_o.op = exe_pkg::exe_sra;
                    isa_pkg::fn_sllv:  dec_o.op = exe_pkg::exe_sllv;
                    isa_pkg::fn_srlv:  dec_o.op = exe_pkg::exe_srlv;
                    isa_pkg::fn_srav:  dec_o.op = exe_pkg::exe_srav;
                    isa_pkg::fn_add:   dec_o.op = exe_pkg::exe_add;
                    isa_pkg::fn_addu:  dec_o.op = exe_pkg::exe_addu;
                    isa_pkg::fn_sub:   dec_o.op = exe_pkg::exe_sub;
                    isa_pkg::fn_subu:  dec_o.op = exe_pkg::exe_subu;
                    isa_pkg::fn_and:   dec_o.op = exe_pkg::exe_and;
                    isa_pkg::fn_or:    dec_o.op = exe_pkg::exe_or;
                    isa_pkg::fn_xor:   dec_o.op = exe_pkg::exe_xor;
                    isa_pkg::fn_nor:   dec_o.op = exe_pkg::exe_nor;
                    isa_pkg::fn_slt:   dec_o.op = exe_pkg::exe_slt;
                    isa_pkg::fn_sltu:  dec_o.op = exe_pkg::exe_sltu;
                    isa_pkg::fn_mfhi:  dec_o.op = exe_pkg::exe_mfhi;
                    isa_pkg::fn_mflo:  dec_o.op = exe_pkg::exe_mflo;
                    isa_pkg::fn_jr: begin
                        dec_o.op   = exe_pkg::exe_jr;
                        dec_o.dest = '0;
                    end
                    isa_pkg::fn_mult: begin
                        dec_o.op   = exe_pkg::exe_mult;
                        dec_o.dest = '0;
                    end
                    isa_pkg::fn_multu: begin
                        dec_o.op   = exe_pkg::exe_multu;
                        dec_o.dest = '0;
                    end
                    default: dec_o.dest = '0;   // unknown funct, no effect
                endcase
            end
            isa_pkg::op_j:   dec_o.op = exe_pkg::exe_j;
            isa_pkg::op_jal: begin
                dec_o.op   = exe_pkg::exe_jal;
                dec_o.dest = 5'd31;             // link register
            end
            isa_pkg::op_beq: dec_o.op = exe_pkg::exe_beq;
            isa_pkg::op_bne: dec_o.op = exe_pkg::exe_bne;
            isa_pkg::op_addi, isa_pkg::op_slti, isa_pkg::op_lw, isa_pkg::op_sw: begin
                dec_o.imm = {{16{imm16[15]}}, imm16};
                case (isa_pkg::opcode_e'(instr_i.opcode))
                    isa_pkg::op_addi: dec_o.op = exe_pkg::exe_addi;
                    isa_pkg::op_slti: dec_o.op = exe_pkg::exe_slti;
                    isa_pkg::op_lw:   dec_o.op = exe_pkg::exe_lw;
                    default:          dec_o.op = exe_pkg::exe_sw;
                endcase
                if (dec_o.op != exe_pkg::exe_sw) begin
                    dec_o.dest = instr_i.rt;
                end
            end
            isa_pkg::op_addiu: begin
                dec_o.op   = exe_pkg::exe_addiu;
                dec_o.dest = instr_i.rt;
            end
            isa_pkg::op_sltiu: begin
                dec_o.op   = exe_pkg::exe_sltiu;
                dec_o.dest = instr_i.rt;
            end
            isa_pkg::op_andi: begin
                dec_o.op   = exe_pkg::exe_andi;
                dec_o.dest = instr_i.rt;
            end
            isa_pkg::op_ori: begin
                dec_o.op   = exe_pkg::exe_ori;
                dec_o.dest = instr_i.rt;
            end
            isa_pkg::op_xori: begin
                dec_o.op   = exe_pkg::exe_xori;
                dec_o.dest = instr_i.rt;
            end
            isa_pkg::op_lui: begin
                dec_o.op   = exe_pkg::exe_lui;
                dec_o.dest = instr_i.rt;
            end
            default: dec_o.op = exe_pkg::exe_nop;
        endcase
    end

endmodule

/* hdl/isa_pkg.sv */
package isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    ////////////////////
    // primary opcodes
    ////////////////////
    typedef enum logic [5:0] {
        op_rtype = 6'b000000,
        op_j     = 6'b000010,
        op_jal   = 6'b000011,
        op_beq   = 6'b000100,
        op_bne   = 6'b000101,
        op_addi  = 6'b001000,
        op_addiu = 6'b001001,
        op_slti  = 6'b001010,
        op_sltiu = 6'b001011,
        op_andi  = 6'b001100,
        op_ori   = 6'b001101,
        op_xori  = 6'b001110,
        op_lui   = 6'b001111,
        op_lw    = 6'b100011,
        op_sw    = 6'b101011
    } opcode_e;

    // R-format function field
    typedef enum logic [5:0] {
        fn_sll   = 6'b000000,
        fn_srl   = 6'b000010,
        fn_sra   = 6'b000011,
        fn_sllv  = 6'b000100,
        fn_srlv  = 6'b000110,
        fn_srav  = 6'b000111,
        fn_jr    = 6'b001000,
        fn_mfhi  = 6'b010000,
        fn_mflo  = 6'b010010,
        fn_mult  = 6'b011000,
        fn_multu = 6'b011001,
        fn_add   = 6'b100000,
        fn_addu  = 6'b100001,
        fn_sub   = 6'b100010,
        fn_subu  = 6'b100011,
        fn_and   = 6'b100100,
        fn_or    = 6'b100101,
        fn_xor   = 6'b100110,
        fn_nor   = 6'b100111,
        fn_slt   = 6'b101010,
        fn_sltu  = 6'b101011
    } funct_e;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [reg_addr_w-1:0] rd;    // imm is [15:0], jump address [25:0]
        logic [reg_addr_w-1:0] shamt;
        logic [5:0]            funct;
    } instr_t;

endpackage

/* hdl/reg_file.sv */
`timescale 1ns/1ps

module reg_file #(
    parameter logic [31:0] sp_init = 32'hfffff000
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic [4:0]        rs_addr_i,
    input  logic [4:0]        rt_addr_i,
    input  exe_pkg::wb_req_t  wb_i,
    output logic [31:0]       rs_val_o,
    output logic [31:0]       rt_val_o
);

    logic [31:0] regs [32];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= (i == 29) ? sp_init : 32'd0;  // r29 is the stack pointer
            end
        end else if (wb_i.we && wb_i.idx != 5'd0) begin
            regs[wb_i.idx] <= wb_i.data;
        end
    end

    ////////////////////
    // reads with bypass of the pending write
    ////////////////////
    always_comb begin
        if (rs_addr_i == 5'd0) begin
            rs_val_o = '0;
        end else if (wb_i.we && wb_i.idx == rs_addr_i) begin
            rs_val_o = wb_i.data;
        end else begin
            rs_val_o = regs[rs_addr_i];
        end

        if (rt_addr_i == 5'd0) begin
            rt_val_o = '0;
        end else if (wb_i.we && wb_i.idx == rt_addr_i) begin
            rt_val_o = wb_i.data;
        end else begin
            rt_val_o = regs[rt_addr_i];
        end
    end

endmodule
